// File: all.f
+incdir+rtl
+incdir+test
rtl/core_pkg.sv
rtl/retire_if.sv
rtl/stage_reg.sv
rtl/fetch_unit.sv
rtl/instr_decoder.sv
rtl/issue_control.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/dual_issue_core.sv
test/tb_dual_issue_core.sv

// File: rtl/alu.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module alu (
  input  core_pkg::alu_op_e op,
  input  core_pkg::xdata_t  a,
  input  core_pkg::xdata_t  b,
  output core_pkg::xdata_t  y
);
  import core_pkg::*;

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [SHAMT_W-1:0] shamt;

  assign shamt = b[SHAMT_W-1:0];  // upper bits of b ignored for shifts

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_SLL:  y = a << shamt;
      ALU_SLT:  y = xdata_t'($signed(a) < $signed(b));
      ALU_SLTU: y = xdata_t'(a < b);
      ALU_XOR:  y = a ^ b;
      ALU_SRL:  y = a >> shamt;
      ALU_SRA:  y = xdata_t'($signed(a) >>> shamt);  // sign fill
      ALU_OR:   y = a | b;
      ALU_AND:  y = a & b;
      default:  y = '0;
    endcase
  end

endmodule

// File: rtl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------
`define XLEN        64  // register and address width
`define INSTR_W     32
`define NUM_REGS    32
`define REG_ADDR_W  5   // log2 of NUM_REGS

// ----------------------------------------
// fetch
// ----------------------------------------
`define PC_STEP     4   // bytes between lane A and lane B words

`endif

// File: rtl/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

  typedef logic [`XLEN-1:0]       xdata_t;
  typedef logic [`INSTR_W-1:0]    instr_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`XLEN-1:0]       addr_t;

  // ----------------------------------------
  // encodings
  // ----------------------------------------
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011
  } opcode_e;

  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,  // srl and sra, told apart by instr[30]
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } funct3_e;

  // low bits follow funct3, bit 3 follows instr[30]
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  // ----------------------------------------
  // pipeline payloads
  // ----------------------------------------
  typedef struct packed {
    alu_op_e   alu_op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      uses_rs2;   // low means the immediate is operand b
    xdata_t    imm;
    logic      writes_rd;
  } uop_t;

  typedef struct packed {
    instr_t a;
    instr_t b;
  } fetch_pair_t;

  typedef struct packed {
    logic   valid;
    uop_t   uop;
    xdata_t rs1_val;
    xdata_t rs2_val;
  } issue_slot_t;

  typedef struct packed {
    issue_slot_t a;
    issue_slot_t b;
  } issue_pair_t;

endpackage

// File: rtl/dual_issue_core.sv
`timescale 1ns/10ps

module dual_issue_core (
  input  logic                clk,
  input  logic                reset,
  input  core_pkg::instr_t    instr_a,
  input  core_pkg::instr_t    instr_b,
  output core_pkg::addr_t     instr_addr,
  output logic                retire_a_valid,
  output core_pkg::reg_addr_t retire_a_rd,
  output core_pkg::xdata_t    retire_a_data,
  output logic                retire_b_valid,
  output core_pkg::reg_addr_t retire_b_rd,
  output core_pkg::xdata_t    retire_b_data
);
  import core_pkg::*;

  fetch_pair_t     pair;
  logic            pair_valid;
  logic            hold;
  issue_pair_t     issue;
  reg_addr_t [3:0] rs_addr;
  xdata_t    [3:0] rs_data;

  retire_if rt ();

  fetch_unit u_fetch (
    .clk(clk), .reset(reset), .hold(hold), .instr_a(instr_a), .instr_b(instr_b),
    .instr_addr(instr_addr), .pair(pair), .pair_valid(pair_valid)
  );

  issue_control u_issue (
    .clk(clk), .reset(reset), .pair(pair), .pair_valid(pair_valid),
    .rs_data(rs_data), .rs_addr(rs_addr), .hold(hold), .issue(issue)
  );

  reg_file u_rf (.clk(clk), .reset(reset), .rs_addr(rs_addr), .wb(rt.sink), .rs_data(rs_data));

  execute_stage u_exec (.clk(clk), .reset(reset), .issue(issue), .rt(rt.source));

  // retire register straight out to the ports
  assign retire_a_valid = rt.a_valid;
  assign retire_a_rd    = rt.a_rd;
  assign retire_a_data  = rt.a_data;
  assign retire_b_valid = rt.b_valid;
  assign retire_b_rd    = rt.b_rd;
  assign retire_b_data  = rt.b_data;

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  core_pkg::issue_pair_t issue,
  retire_if.source              rt
);
  import core_pkg::*;

  xdata_t a_op1;
  xdata_t a_op2;
  xdata_t b_op1;
  xdata_t b_op2;
  xdata_t a_res;
  xdata_t b_res;

  // previous pair's result if it wrote addr, lane B being the younger
  function automatic xdata_t fwd(input reg_addr_t addr, input xdata_t rf_val);
    if (rt.b_valid && rt.b_rd == addr)
      return rt.b_data;
    if (rt.a_valid && rt.a_rd == addr)
      return rt.a_data;
    return rf_val;
  endfunction

  // ----------------------------------------
  // operand select
  // ----------------------------------------
  always_comb begin
    a_op1 = fwd(issue.a.uop.rs1, issue.a.rs1_val);
    a_op2 = issue.a.uop.uses_rs2 ? fwd(issue.a.uop.rs2, issue.a.rs2_val) : issue.a.uop.imm;
    b_op1 = fwd(issue.b.uop.rs1, issue.b.rs1_val);
    b_op2 = issue.b.uop.uses_rs2 ? fwd(issue.b.uop.rs2, issue.b.rs2_val) : issue.b.uop.imm;
  end

  alu u_alu_a (.op(issue.a.uop.alu_op), .a(a_op1), .b(a_op2), .y(a_res));
  alu u_alu_b (.op(issue.b.uop.alu_op), .a(b_op1), .b(b_op2), .y(b_res));

  // ----------------------------------------
  // retire register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      rt.a_valid <= 1'b0;
      rt.b_valid <= 1'b0;
    end else begin
      rt.a_valid <= issue.a.valid && issue.a.uop.writes_rd;
      rt.b_valid <= issue.b.valid && issue.b.uop.writes_rd;
    end
  end

  always_ff @(posedge clk) begin
    rt.a_rd   <= issue.a.uop.rd;
    rt.a_data <= a_res;
    rt.b_rd   <= issue.b.uop.rd;
    rt.b_data <= b_res;
  end

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module fetch_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  hold,
  input  core_pkg::instr_t      instr_a,
  input  core_pkg::instr_t      instr_b,
  output core_pkg::addr_t       instr_addr,
  output core_pkg::fetch_pair_t pair,
  output logic                  pair_valid
);
  import core_pkg::*;

  addr_t       pc;
  fetch_pair_t fetched;

  assign instr_addr = pc;
  assign fetched.a  = instr_a;  // word at pc
  assign fetched.b  = instr_b;  // word at pc + PC_STEP

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= '0;
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= 1'b1;  // first pair lands at the end of this cycle
      if (!hold)
        pc <= pc + addr_t'(2 * `PC_STEP);
    end
  end

  stage_reg #(.payload_t(fetch_pair_t)) u_pair_reg (
    .clk    (clk),
    .reset  (reset),
    .hold   (hold),
    .bubble (1'b0),
    .d      (fetched),
    .q      (pair)
  );

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module instr_decoder (
  input  core_pkg::instr_t instr,
  output core_pkg::uop_t   uop
);
  import core_pkg::*;

  funct3_e    funct3;
  logic [6:0] funct7;
  logic       is_op;
  logic       is_imm;
  logic       alt_ok;  // instr[30] may be set
  logic       legal;
  alu_op_e    op_sel;

  assign funct3 = funct3_e'(instr[14:12]);
  assign funct7 = instr[31:25];
  assign is_op  = (instr[6:0] == OP);
  assign is_imm = (instr[6:0] == OP_IMM);
  assign alt_ok = (is_op && funct3 == F3_ADD) || funct3 == F3_SR;

  always_comb begin
    case (funct3)
      F3_ADD:  op_sel = (is_op && instr[30]) ? ALU_SUB : ALU_ADD;  // no subi
      F3_SLL:  op_sel = ALU_SLL;
      F3_SLT:  op_sel = ALU_SLT;
      F3_SLTU: op_sel = ALU_SLTU;
      F3_XOR:  op_sel = ALU_XOR;
      F3_SR:   op_sel = instr[30] ? ALU_SRA : ALU_SRL;
      F3_OR:   op_sel = ALU_OR;
      default: op_sel = ALU_AND;
    endcase
  end

  // reject the funct7 / shift-top patterns this core does not execute
  always_comb begin
    if (is_op)
      legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000 && alt_ok);
    else if (funct3 == F3_SLL || funct3 == F3_SR)
      legal = (instr[31:26] == 6'b000000) || (instr[31:26] == 6'b010000 && alt_ok);
    else
      legal = 1'b1;
  end

  always_comb begin
    uop.alu_op    = op_sel;
    uop.rd        = instr[11:7];
    uop.rs1       = instr[19:15];
    uop.rs2       = instr[24:20];
    uop.uses_rs2  = is_op;
    uop.imm       = {{(`XLEN-12){instr[31]}}, instr[31:20]};  // I-type, sign extended
    uop.writes_rd = (is_op || is_imm) && legal && (instr[11:7] != '0);
  end

endmodule

// File: rtl/issue_control.sv
`timescale 1ns/10ps

module issue_control (
  input  logic                      clk,
  input  logic                      reset,
  input  core_pkg::fetch_pair_t     pair,
  input  logic                      pair_valid,
  input  core_pkg::xdata_t    [3:0] rs_data,
  output core_pkg::reg_addr_t [3:0] rs_addr,
  output logic                      hold,
  output core_pkg::issue_pair_t     issue
);
  import core_pkg::*;

  uop_t        uop_a;
  uop_t        uop_b;
  logic        dep;
  logic        split_now;
  logic        second_half;  // lane B of a split pair goes this cycle
  issue_pair_t next_issue;

  instr_decoder u_dec_a (.instr(pair.a), .uop(uop_a));
  instr_decoder u_dec_b (.instr(pair.b), .uop(uop_b));

  // read ports 0/1 serve lane A, 2/3 lane B
  assign rs_addr[0] = uop_a.rs1;
  assign rs_addr[1] = uop_a.rs2;
  assign rs_addr[2] = uop_b.rs1;
  assign rs_addr[3] = uop_b.rs2;

  // ----------------------------------------
  // intra-pair dependency
  // ----------------------------------------
  // B reads the register that A writes
  assign dep = uop_a.writes_rd &&
               (uop_b.rs1 == uop_a.rd || (uop_b.uses_rs2 && uop_b.rs2 == uop_a.rd));

  assign split_now = pair_valid && dep && !second_half;
  assign hold      = split_now;  // refetch nothing, the pair stays for lane B

  always_ff @(posedge clk) begin
    if (reset)
      second_half <= 1'b0;
    else
      second_half <= split_now;
  end

  always_comb begin
    next_issue.a.valid   = !second_half;  // A already went
    next_issue.a.uop     = uop_a;
    next_issue.a.rs1_val = rs_data[0];
    next_issue.a.rs2_val = rs_data[1];
    next_issue.b.valid   = !split_now;
    next_issue.b.uop     = uop_b;
    next_issue.b.rs1_val = rs_data[2];
    next_issue.b.rs2_val = rs_data[3];
  end

  stage_reg #(.payload_t(issue_pair_t)) u_issue_reg (
    .clk    (clk),
    .reset  (reset),
    .hold   (1'b0),
    .bubble (!pair_valid),
    .d      (next_issue),
    .q      (issue)
  );

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module reg_file (
  input  logic                      clk,
  input  logic                      reset,
  input  core_pkg::reg_addr_t [3:0] rs_addr,
  retire_if.sink                    wb,
  output core_pkg::xdata_t    [3:0] rs_data
);
  import core_pkg::*;

  localparam int NUM_READ = 4;

  xdata_t regs [`NUM_REGS];

  // B after A so the younger write wins on the same rd
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb.a_valid && wb.a_rd != '0)
        regs[wb.a_rd] <= wb.a_data;
      if (wb.b_valid && wb.b_rd != '0)
        regs[wb.b_rd] <= wb.b_data;
    end
  end

  // ----------------------------------------
  // reads with write-through
  // ----------------------------------------
  always_comb begin
    for (int p = 0; p < NUM_READ; p++) begin
      if (rs_addr[p] == '0)
        rs_data[p] = '0;                          // x0 reads as zero
      else if (wb.b_valid && wb.b_rd == rs_addr[p])
        rs_data[p] = wb.b_data;
      else if (wb.a_valid && wb.a_rd == rs_addr[p])
        rs_data[p] = wb.a_data;
      else
        rs_data[p] = regs[rs_addr[p]];
    end
  end

endmodule

// File: rtl/retire_if.sv
`timescale 1ns/10ps

interface retire_if;
  import core_pkg::*;

  // lane A, older of the two
  logic      a_valid;
  reg_addr_t a_rd;
  xdata_t    a_data;

  // lane B
  logic      b_valid;
  reg_addr_t b_rd;
  xdata_t    b_data;

  // source also reads these back for forwarding
  modport source (output a_valid, a_rd, a_data, b_valid, b_rd, b_data);

  modport sink   (input  a_valid, a_rd, a_data, b_valid, b_rd, b_data);

endinterface

// File: rtl/stage_reg.sv
`timescale 1ns/10ps

// generic pipeline register, zero payload means an empty stage
module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     hold,    // keep current contents
  input  logic     bubble,  // load an empty payload instead of d
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (reset || bubble) begin
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

// File: test/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// ----------------------------------------
// program generator
// ----------------------------------------
function automatic instr_t rand_op(input reg_addr_t rd, input reg_addr_t rs1,
                                  input reg_addr_t rs2);
  logic [2:0] f3;
  logic       alt;
  f3  = 3'($urandom % 8);
  alt = (f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1);  // sub or sra
  return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};
endfunction

function automatic instr_t rand_imm(input reg_addr_t rd, input reg_addr_t rs1, input logic neg);
  logic [2:0]  f3;
  logic [11:0] imm;
  f3  = 3'($urandom % 8);
  imm = 12'($urandom);
  if (neg)
    imm[11] = 1'b1;
  if (f3 == 3'd1)
    imm[11:6] = 6'b000000;
  if (f3 == 3'd5)
    imm[11:6] = ($urandom % 2 == 1) ? 6'b010000 : 6'b000000;  // srai or srli
  return {imm, rs1, f3, rd, OP_IMM};
endfunction

function automatic reg_addr_t low_reg(input reg_addr_t avoid);
  reg_addr_t r;
  r = reg_addr_t'($urandom % 8);
  return (r == avoid) ? reg_addr_t'(0) : r;
endfunction

// x0 writes, unknown opcodes and x0 reads
function automatic instr_t odd_word();
  instr_t w;
  w = instr_t'($urandom);
  case ($urandom % 3)
    0: return rand_op(5'd0, reg_addr_t'($urandom % 8), reg_addr_t'($urandom % 8));
    1: begin
      w[6:0] = ($urandom % 2 == 1) ? 7'b0000011 : 7'b1100011;  // load, branch
      return w;
    end
    default: return rand_imm(reg_addr_t'(1 + $urandom % 7), 5'd0, 1'b0);
  endcase
endfunction

task automatic gen_pair(input int mode, input int idx);
  reg_addr_t ard;
  ard = reg_addr_t'(1 + $urandom % 7);
  case (mode)
    0: begin
      if (idx < 8) begin  // seed x1..x8
        prog[idx]     = {12'($urandom), 5'd0, 3'd0, reg_addr_t'(idx + 1), OP_IMM};
        prog[idx + 1] = {12'($urandom), 5'd0, 3'd0, reg_addr_t'(idx + 2), OP_IMM};
      end else begin
        prog[idx]     = rand_op(reg_addr_t'(9 + $urandom % 7),
                                reg_addr_t'(1 + $urandom % 8), reg_addr_t'(1 + $urandom % 8));
        prog[idx + 1] = rand_op(reg_addr_t'(16 + $urandom % 8),
                                reg_addr_t'(1 + $urandom % 8), reg_addr_t'(1 + $urandom % 8));
      end
    end
    1: begin
      prog[idx]     = rand_imm(ard, reg_addr_t'($urandom % 8), 1'b1);
      prog[idx + 1] = rand_imm(reg_addr_t'(1 + $urandom % 7), reg_addr_t'($urandom % 8), 1'b1);
    end
    2: begin  // B stays off A's rd, reads the older pairs instead
      prog[idx]     = rand_op(ard, reg_addr_t'($urandom % 8), reg_addr_t'($urandom % 8));
      prog[idx + 1] = ($urandom % 2 == 1)
                      ? rand_op(reg_addr_t'(1 + $urandom % 7), low_reg(ard), low_reg(ard))
                      : rand_imm(reg_addr_t'(1 + $urandom % 7), low_reg(ard), 1'b0);
    end
    3: begin  // B reads A's rd
      prog[idx]     = rand_imm(ard, reg_addr_t'($urandom % 8), 1'b0);
      prog[idx + 1] = ($urandom % 2 == 1)
                      ? rand_op(reg_addr_t'(1 + $urandom % 7), ard, reg_addr_t'($urandom % 8))
                      : rand_imm(reg_addr_t'(1 + $urandom % 7), ard, 1'b0);
    end
    default: begin
      prog[idx]     = odd_word();
      prog[idx + 1] = odd_word();
    end
  endcase
endtask

// ----------------------------------------
// in-order reference model
// ----------------------------------------
function automatic logic has_write(input instr_t w);
  return (w[6:0] == OP || w[6:0] == OP_IMM) && w[11:7] != 5'd0;
endfunction

function automatic xdata_t model_alu(input instr_t w, input xdata_t a, input xdata_t b);
  logic [5:0] sh;
  sh = b[5:0];
  case (w[14:12])
    3'd0: return (w[6:0] == OP && w[30]) ? a - b : a + b;
    3'd1: return a << sh;
    3'd2: return ($signed(a) < $signed(b)) ? xdata_t'(1) : xdata_t'(0);
    3'd3: return (a < b) ? xdata_t'(1) : xdata_t'(0);
    3'd4: return a ^ b;
    3'd5: return w[30] ? xdata_t'($signed(a) >>> sh) : a >> sh;
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

task automatic run_model(input int n);
  xdata_t mregs [`NUM_REGS];
  xdata_t opb;
  instr_t w;
  instr_t wb;
  exp_rd.delete();
  exp_data.delete();
  exp_splits = 0;
  foreach (mregs[i]) mregs[i] = '0;
  for (int i = 0; i < n; i++) begin
    w   = prog[i];
    opb = (w[6:0] == OP) ? mregs[w[24:20]] : {{(`XLEN-12){w[31]}}, w[31:20]};
    if (has_write(w)) begin
      mregs[w[11:7]] = model_alu(w, mregs[w[19:15]], opb);
      exp_rd.push_back(w[11:7]);
      exp_data.push_back(mregs[w[11:7]]);
    end
  end
  for (int i = 0; i < n; i += 2) begin  // pairs whose B reads A's rd
    w  = prog[i];
    wb = prog[i + 1];
    if (has_write(w) &&
        (wb[19:15] == w[11:7] || (wb[6:0] == OP && wb[24:20] == w[11:7])))
      exp_splits++;
  end
endtask

`endif

// File: test/tb_dual_issue_core.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module tb_dual_issue_core;
  import core_pkg::*;

  localparam int     MEM_WORDS = 128;
  localparam instr_t NOP       = 32'h00000013;  // addi x0, x0, 0
  localparam int     N_INDEP   = 48;
  localparam int     N_IMM     = 40;
  localparam int     N_CHAIN   = 48;
  localparam int     N_DEP     = 32;
  localparam int     N_ODD     = 40;
  localparam int     N_TOTAL   = N_INDEP + N_IMM + N_CHAIN + N_DEP + N_ODD;

  logic      clk = 1'b0;
  logic      reset;
  instr_t    instr_a;
  instr_t    instr_b;
  addr_t     instr_addr;
  logic      retire_a_valid;
  reg_addr_t retire_a_rd;
  xdata_t    retire_a_data;
  logic      retire_b_valid;
  reg_addr_t retire_b_rd;
  xdata_t    retire_b_data;

  instr_t    prog [MEM_WORDS];
  reg_addr_t exp_rd[$];
  xdata_t    exp_data[$];
  int        exp_splits;
  int        errors = 0;
  int        tests_run = 0;
  int        tests_failed = 0;

  `include "core_model.svh"

  dual_issue_core UUT (
    .clk(clk), .reset(reset), .instr_a(instr_a), .instr_b(instr_b), .instr_addr(instr_addr),
    .retire_a_valid(retire_a_valid), .retire_a_rd(retire_a_rd), .retire_a_data(retire_a_data),
    .retire_b_valid(retire_b_valid), .retire_b_rd(retire_b_rd), .retire_b_data(retire_b_data)
  );

  always #10 clk = ~clk;

  // ----------------------------------------
  // program memory, words past the end are nops
  // ----------------------------------------
  function automatic instr_t fetch_word(input addr_t addr);
    if ((addr >> 2) < MEM_WORDS)
      return prog[addr >> 2];
    return NOP;
  endfunction

  always @(negedge clk) begin
    instr_a <= fetch_word(instr_addr);
    instr_b <= fetch_word(instr_addr + `PC_STEP);
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_flag(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %b expected %b", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string sig, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic check_rd(input string sig, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got x%0d expected x%0d", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic check_data(input string sig, input xdata_t got, input xdata_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic take_retire(input string lane, input reg_addr_t rd, input xdata_t data);
    if (exp_rd.size() == 0) begin
      $display("lane %s retired x%0d at %0t but no write was left", lane, rd, $time);
      errors++;
    end else begin
      check_rd({"retire_", lane, "_rd"}, rd, exp_rd.pop_front());
      check_data({"retire_", lane, "_data"}, data, exp_data.pop_front());
    end
  endtask

  task automatic run_test(input string name, input int mode, input int n);
    int    err0;
    int    idle;
    int    repeats;
    addr_t prev;
    err0 = errors;
    foreach (prog[i]) prog[i] = NOP;
    for (int i = 0; i < n; i += 2)
      gen_pair(mode, i);
    run_model(n);
    reset = 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_flag("retire_a_valid", retire_a_valid, 1'b0);
      check_flag("retire_b_valid", retire_b_valid, 1'b0);
      check_addr("instr_addr", instr_addr, '0);
    end
    reset   = 1'b0;
    prev    = instr_addr;
    repeats = 0;
    idle    = 0;
    while (exp_rd.size() > 0 || idle < 8) begin  // a few idle cycles catch extra retires
      @(negedge clk);
      if (instr_addr == prev)
        repeats++;
      prev = instr_addr;
      if (retire_a_valid)
        take_retire("a", retire_a_rd, retire_a_data);
      if (retire_b_valid)
        take_retire("b", retire_b_rd, retire_b_data);
      if (exp_rd.size() == 0)
        idle++;
    end
    if (repeats != exp_splits) begin
      $display("instr_addr held %0d times but %0d pairs should split", repeats, exp_splits);
      errors++;
    end
    tests_run++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err0);
    end
  endtask

  // ----------------------------------------
  // main sequence and watchdog
  // ----------------------------------------
  initial begin
    void'($urandom(32'hbd4438c5));
    reset   = 1'b1;
    instr_a = NOP;
    instr_b = NOP;
    run_test("independent", 0, N_INDEP);
    run_test("immediates", 1, N_IMM);
    run_test("chains", 2, N_CHAIN);
    run_test("split_pairs", 3, N_DEP);
    run_test("x0_and_unknown", 4, N_ODD);
    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #((4 * N_TOTAL + 100) * 20);
    $display("watchdog expired before all tests finished");
    $display("Test failures found");
    $finish;
  end

endmodule
